//--- cpu8_pkg.sv
package cpu8_pkg;

	localparam int DATA_W = 8;
	localparam int REG_CNT = 8;
	localparam int REG_SEL_W = 3;
	localparam int PC_W = 8;
	localparam int ROM_DEPTH = 256;     // one word per pc value
	localparam int TRACE_WORDS = 7;
	localparam string PROGRAM_FILE = "program.hex";

	typedef logic signed [DATA_W-1:0] data_t;

	// 8080 layout gg ddd sss
	typedef struct packed {
		logic [1:0] grp;
		logic [2:0] dst;
		logic [2:0] src;
	} instr_fields_t;

	typedef union packed {
		logic [7:0] raw;
		instr_fields_t fields;
	} instr_t;

	typedef enum logic [3:0] {
		ADD, ADC, SUB, SBB, INC, DEC, AND,
		OR, XOR, NOT, RLC, RRC, RAL, RAR
	} alu_op_t;

	// order of the words in one trace record
	typedef enum logic [2:0] {
		OPCODE    = 3'd0,
		OPERAND_A = 3'd1,
		OPERAND_B = 3'd2,
		RESULT    = 3'd3,
		CARRY     = 3'd4,
		BORROW    = 3'd5,
		PC        = 3'd6
	} trace_kind_t;

	// whole-byte opcodes
	localparam logic [7:0] OP_NOP = 8'h00;
	localparam logic [7:0] OP_JMP = 8'hc3;
	localparam logic [7:0] OP_HLT = 8'h76;   // sits inside the mov group
	localparam logic [7:0] OP_CMC = 8'h3f;
	localparam logic [7:0] OP_CMA = 8'h2f;
	localparam logic [7:0] OP_RLC = 8'h07;
	localparam logic [7:0] OP_RRC = 8'h0f;
	localparam logic [7:0] OP_RAL = 8'h17;
	localparam logic [7:0] OP_RAR = 8'h1f;

	localparam logic [1:0] GRP_IMM = 2'b00;  // mvi, inr, dcr
	localparam logic [1:0] GRP_MOV = 2'b01;
	localparam logic [1:0] GRP_ALU = 2'b10;
	localparam logic [1:0] GRP_JCC = 2'b11;

	localparam logic [2:0] SUB_INR = 3'b100;
	localparam logic [2:0] SUB_DCR = 3'b101;
	localparam logic [2:0] SUB_MVI = 3'b110;
	localparam logic [2:0] SUB_JPOS = 3'b010;

	// register forms, low three bits select the source
	localparam logic [4:0] ARITH_ADD = 5'b10000;
	localparam logic [4:0] ARITH_ADC = 5'b10001;
	localparam logic [4:0] ARITH_SUB = 5'b10010;
	localparam logic [4:0] ARITH_SBB = 5'b10011;
	localparam logic [4:0] ARITH_ANA = 5'b10100;
	localparam logic [4:0] ARITH_XRA = 5'b10101;
	localparam logic [4:0] ARITH_ORA = 5'b10110;
	localparam logic [4:0] ARITH_CMP = 5'b10111;

endpackage

//--- alu.sv
`timescale 1ns/10ps

module alu (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  cpu8_pkg::alu_op_t op,
	input  cpu8_pkg::data_t a,
	input  cpu8_pkg::data_t b,
	input  logic carry_in,
	input  logic borrow_in,
	output cpu8_pkg::data_t result,
	output logic carry_out,
	output logic borrow_out,
	output logic done
);
	import cpu8_pkg::*;

	logic [DATA_W:0] sum;   // sign extended with a guard bit
	logic arith;
	data_t nxt_result;
	logic nxt_carry;
	logic nxt_borrow;

	always_comb begin
		sum = '0;
		arith = 1'b0;
		nxt_result = a;
		nxt_carry = 1'b0;
		nxt_borrow = 1'b0;
		case (op)
			ADD: begin
				arith = 1'b1;
				sum = {a[DATA_W-1], a} + {b[DATA_W-1], b};
			end
			ADC: begin
				arith = 1'b1;
				sum = {a[DATA_W-1], a} + {b[DATA_W-1], b} + carry_in;
			end
			SUB: begin
				arith = 1'b1;
				sum = {a[DATA_W-1], a} - {b[DATA_W-1], b};
			end
			SBB: begin
				arith = 1'b1;
				sum = {a[DATA_W-1], a} - {b[DATA_W-1], b} - borrow_in;
			end
			INC: begin
				arith = 1'b1;
				sum = {a[DATA_W-1], a} + 1'b1;
			end
			DEC: begin
				arith = 1'b1;
				sum = {a[DATA_W-1], a} - 1'b1;
			end
			AND: nxt_result = a & b;
			OR:  nxt_result = a | b;
			XOR: nxt_result = a ^ b;
			NOT: nxt_result = ~a;
			RLC: begin
				nxt_result = {a[DATA_W-2:0], a[DATA_W-1]};
				nxt_carry = carry_in;               // plain rotate keeps carry
			end
			RRC: begin
				nxt_result = {a[0], a[DATA_W-1:1]};
				nxt_carry = carry_in;
			end
			RAL: begin
				nxt_result = {a[DATA_W-2:0], carry_in};
				nxt_carry = a[DATA_W-1];
			end
			RAR: begin
				nxt_result = {carry_in, a[DATA_W-1:1]};
				nxt_carry = a[0];
			end
			default: nxt_result = a;
		endcase

		// guard bit differs from bit 7 only on signed overflow,
		// so taking it as bit 7 flips that bit exactly then
		if (arith) begin
			nxt_result = {sum[DATA_W], sum[DATA_W-2:0]};
			nxt_carry = !sum[DATA_W] && sum[DATA_W-1];    // went past +127
			nxt_borrow = sum[DATA_W] && !sum[DATA_W-1];   // went below -128
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			done <= 1'b0;
		else
			done <= start;
	end

	always_ff @(posedge clk) begin
		if (start) begin
			result <= nxt_result;
			carry_out <= nxt_carry;
			borrow_out <= nxt_borrow;
		end
	end

	// start is a one-cycle pulse and done answers it next cycle
	a_done_after_start: assert property (@(posedge clk) disable iff (rst)
		start |=> done && !start);

endmodule

//--- reg_file.sv
`timescale 1ns/10ps

module reg_file (
	input  logic clk,
	input  logic rst,
	input  logic [cpu8_pkg::REG_SEL_W-1:0] rd_sel_a,
	input  logic [cpu8_pkg::REG_SEL_W-1:0] rd_sel_b,
	input  logic wr_en,
	input  logic [cpu8_pkg::REG_SEL_W-1:0] wr_sel,
	input  cpu8_pkg::data_t wr_data,
	output cpu8_pkg::data_t rd_a,
	output cpu8_pkg::data_t rd_b
);
	import cpu8_pkg::*;

	// r0 doubles as the accumulator
	data_t regs [REG_CNT];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < REG_CNT; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_sel] <= wr_data;
		end
	end

	// async read, core decodes in the same cycle
	assign rd_a = regs[rd_sel_a];
	assign rd_b = regs[rd_sel_b];

endmodule

//--- cpu_control.sv
`timescale 1ns/10ps

module cpu_control (
	input  logic clk,
	input  logic rst,
	input  logic alu_done,
	input  cpu8_pkg::data_t alu_result,
	input  logic alu_carry,
	input  logic alu_borrow,
	input  cpu8_pkg::data_t rd_a,
	input  cpu8_pkg::data_t rd_b,
	input  logic rec_next,
	output logic alu_start,
	output cpu8_pkg::alu_op_t alu_op,
	output cpu8_pkg::data_t alu_a,
	output cpu8_pkg::data_t alu_b,
	output logic carry_flag,
	output logic borrow_flag,
	output logic [cpu8_pkg::REG_SEL_W-1:0] rd_sel_a,
	output logic [cpu8_pkg::REG_SEL_W-1:0] rd_sel_b,
	output logic wr_en,
	output logic [cpu8_pkg::REG_SEL_W-1:0] wr_sel,
	output cpu8_pkg::data_t wr_data,
	output logic rec_valid,
	output logic [cpu8_pkg::DATA_W-1:0] rec_opcode,
	output cpu8_pkg::data_t rec_a,
	output cpu8_pkg::data_t rec_b,
	output cpu8_pkg::data_t rec_result,
	output logic rec_carry,
	output logic rec_borrow,
	output logic [cpu8_pkg::PC_W-1:0] rec_pc,
	output logic halted
);
	import cpu8_pkg::*;

	typedef enum logic [2:0] {
		S_FETCH, S_DECODE, S_START, S_WAIT, S_WB, S_REPORT, S_HALT
	} state_t;

	state_t state;
	logic [2*DATA_W-1:0] rom [ROM_DEPTH];
	logic [PC_W-1:0] pc;
	instr_t ir;
	logic [DATA_W-1:0] imm;
	data_t last_result;
	data_t wb_data;
	logic [REG_SEL_W-1:0] wb_sel;
	logic wb_en;
	logic alu_instr;     // writeback takes result and flags from the alu

	logic is_mov;
	logic is_mvi;
	logic is_inr;
	logic is_dcr;
	logic is_jpos;
	logic is_cmp;
	logic dec_alu;
	alu_op_t dec_op;

	initial $readmemh(PROGRAM_FILE, rom);

	// field view of the instruction byte
	assign is_mov = ir.fields.grp == GRP_MOV;
	assign is_mvi = ir.fields.grp == GRP_IMM && ir.fields.src == SUB_MVI;
	assign is_inr = ir.fields.grp == GRP_IMM && ir.fields.src == SUB_INR;
	assign is_dcr = ir.fields.grp == GRP_IMM && ir.fields.src == SUB_DCR;
	assign is_jpos = ir.fields.grp == GRP_JCC && ir.fields.src == SUB_JPOS;
	assign is_cmp = {ir.fields.grp, ir.fields.dst} == ARITH_CMP;

	always_comb begin
		dec_alu = 1'b1;
		dec_op = ADD;
		if (is_inr)
			dec_op = INC;
		else if (is_dcr)
			dec_op = DEC;
		else begin
			case (ir.raw)
				OP_RLC: dec_op = RLC;
				OP_RRC: dec_op = RRC;
				OP_RAL: dec_op = RAL;
				OP_RAR: dec_op = RAR;
				OP_CMA: dec_op = NOT;
				default: begin
					case ({ir.fields.grp, ir.fields.dst})
						ARITH_ADD: dec_op = ADD;
						ARITH_ADC: dec_op = ADC;
						ARITH_SUB: dec_op = SUB;
						ARITH_SBB: dec_op = SBB;
						ARITH_ANA: dec_op = AND;
						ARITH_XRA: dec_op = XOR;
						ARITH_ORA: dec_op = OR;
						ARITH_CMP: dec_op = SUB;   // flags only
						default: dec_alu = 1'b0;
					endcase
				end
			endcase
		end
	end

	// port a reads the named register for inr, dcr and jpos, else r0
	assign rd_sel_a = (is_inr || is_dcr || is_jpos) ? ir.fields.dst : '0;
	assign rd_sel_b = ir.fields.src;

	always_ff @(posedge clk) begin
		if (state == S_FETCH)
			{ir, imm} <= rom[pc];
		if (state == S_DECODE) begin
			alu_op <= dec_op;
			wb_sel <= (dec_alu && !is_inr && !is_dcr) ? '0 : ir.fields.dst;
			wb_data <= is_mov ? rd_b : data_t'(imm);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_FETCH;
			pc <= '0;
			carry_flag <= 1'b0;
			borrow_flag <= 1'b0;
			halted <= 1'b0;
			alu_a <= '0;
			alu_b <= '0;
			last_result <= '0;
			wb_en <= 1'b0;
			alu_instr <= 1'b0;
		end else begin
			case (state)
				S_FETCH: state <= S_DECODE;
				S_DECODE: begin
					if (ir.raw == OP_HLT) begin
						halted <= 1'b1;
						state <= S_HALT;
					end else begin
						pc <= pc + 1'b1;
						alu_instr <= dec_alu;
						wb_en <= dec_alu ? !is_cmp : (is_mov || is_mvi);
						state <= dec_alu ? S_START : S_WB;
						if (ir.raw == OP_JMP || (is_jpos && rd_a > 0))
							pc <= imm;
						if (ir.raw == OP_CMC)
							carry_flag <= !carry_flag;
						if (dec_alu) begin
							alu_a <= rd_a;
							alu_b <= (ir.fields.grp == GRP_ALU) ? rd_b : '0;
						end
					end
				end
				S_START: state <= S_WAIT;
				S_WAIT: begin
					if (alu_done)
						state <= S_WB;
				end
				S_WB: begin
					if (alu_instr) begin
						last_result <= alu_result;
						carry_flag <= alu_carry;
						borrow_flag <= alu_borrow;
					end
					state <= S_REPORT;
				end
				S_REPORT: begin
					if (rec_next)
						state <= S_FETCH;
				end
				S_HALT: state <= S_HALT;   // only reset leaves
				default: state <= S_FETCH;
			endcase
		end
	end

	assign alu_start = state == S_START;
	assign wr_en = state == S_WB && wb_en;
	assign wr_sel = wb_sel;
	assign wr_data = alu_instr ? alu_result : wb_data;

	// record held steady for the whole report state
	assign rec_valid = state == S_REPORT;
	assign rec_opcode = ir.raw;
	assign rec_a = alu_a;
	assign rec_b = alu_b;
	assign rec_result = last_result;
	assign rec_carry = carry_flag;
	assign rec_borrow = borrow_flag;
	assign rec_pc = pc;

	// result comes back next cycle, no second start overlaps it
	a_no_start_pending: assert property (@(posedge clk) disable iff (rst)
		alu_start |=> alu_done && !alu_start);

endmodule

//--- trace_sequencer.sv
`timescale 1ns/10ps

module trace_sequencer (
	input  logic clk,
	input  logic rst,
	input  logic rec_valid,
	input  logic [cpu8_pkg::DATA_W-1:0] rec_opcode,
	input  cpu8_pkg::data_t rec_a,
	input  cpu8_pkg::data_t rec_b,
	input  cpu8_pkg::data_t rec_result,
	input  logic rec_carry,
	input  logic rec_borrow,
	input  logic [cpu8_pkg::PC_W-1:0] rec_pc,
	output logic [cpu8_pkg::DATA_W-1:0] data_out,
	output cpu8_pkg::trace_kind_t data_type,
	output logic data_valid,
	output logic rec_next
);
	import cpu8_pkg::*;

	trace_kind_t kind;   // word counter, doubles as the type tag
	logic busy;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			kind <= OPCODE;
			rec_next <= 1'b0;
		end else begin
			rec_next <= 1'b0;
			if (!busy) begin
				// rec_valid is still up while rec_next is out
				if (rec_valid && !rec_next) begin
					busy <= 1'b1;
					kind <= OPCODE;
				end
			end else if (kind == trace_kind_t'(TRACE_WORDS - 1)) begin
				busy <= 1'b0;
				rec_next <= 1'b1;
			end else begin
				kind <= trace_kind_t'(kind + 1'b1);
			end
		end
	end

	always_comb begin
		case (kind)
			OPCODE:    data_out = rec_opcode;
			OPERAND_A: data_out = rec_a;
			OPERAND_B: data_out = rec_b;
			RESULT:    data_out = rec_result;
			CARRY:     data_out = {{(DATA_W-1){1'b0}}, rec_carry};
			BORROW:    data_out = {{(DATA_W-1){1'b0}}, rec_borrow};
			default:   data_out = rec_pc;
		endcase
	end

	assign data_valid = busy;
	assign data_type = kind;

	a_type_range: assert property (@(posedge clk) disable iff (rst)
		data_valid |-> data_type <= PC);

	// core keeps its record up until released
	a_record_held: assert property (@(posedge clk) disable iff (rst)
		data_valid |-> rec_valid);

endmodule

//--- cpu_top.sv
`timescale 1ns/10ps

module cpu_top (
	input  logic clk,
	input  logic rst,
	output logic [cpu8_pkg::DATA_W-1:0] data_out,
	output cpu8_pkg::trace_kind_t data_type,
	output logic data_valid,
	output logic halted
);
	import cpu8_pkg::*;

	// core and alu
	logic alu_start;
	logic alu_done;
	alu_op_t alu_op;
	data_t alu_a;
	data_t alu_b;
	data_t alu_result;
	logic alu_carry;
	logic alu_borrow;
	logic carry_flag;
	logic borrow_flag;

	// register file
	logic [REG_SEL_W-1:0] rd_sel_a;
	logic [REG_SEL_W-1:0] rd_sel_b;
	data_t rd_a;
	data_t rd_b;
	logic wr_en;
	logic [REG_SEL_W-1:0] wr_sel;
	data_t wr_data;

	// trace record
	logic rec_valid;
	logic rec_next;
	logic [DATA_W-1:0] rec_opcode;
	data_t rec_a;
	data_t rec_b;
	data_t rec_result;
	logic rec_carry;
	logic rec_borrow;
	logic [PC_W-1:0] rec_pc;

	cpu_control u_ctrl (
		.clk(clk),
		.rst(rst),
		.alu_done(alu_done),
		.alu_result(alu_result),
		.alu_carry(alu_carry),
		.alu_borrow(alu_borrow),
		.rd_a(rd_a),
		.rd_b(rd_b),
		.rec_next(rec_next),
		.alu_start(alu_start),
		.alu_op(alu_op),
		.alu_a(alu_a),
		.alu_b(alu_b),
		.carry_flag(carry_flag),
		.borrow_flag(borrow_flag),
		.rd_sel_a(rd_sel_a),
		.rd_sel_b(rd_sel_b),
		.wr_en(wr_en),
		.wr_sel(wr_sel),
		.wr_data(wr_data),
		.rec_valid(rec_valid),
		.rec_opcode(rec_opcode),
		.rec_a(rec_a),
		.rec_b(rec_b),
		.rec_result(rec_result),
		.rec_carry(rec_carry),
		.rec_borrow(rec_borrow),
		.rec_pc(rec_pc),
		.halted(halted)
	);

	alu u_alu (
		.clk(clk),
		.rst(rst),
		.start(alu_start),
		.op(alu_op),
		.a(alu_a),
		.b(alu_b),
		.carry_in(carry_flag),
		.borrow_in(borrow_flag),
		.result(alu_result),
		.carry_out(alu_carry),
		.borrow_out(alu_borrow),
		.done(alu_done)
	);

	reg_file u_regs (
		.clk(clk),
		.rst(rst),
		.rd_sel_a(rd_sel_a),
		.rd_sel_b(rd_sel_b),
		.wr_en(wr_en),
		.wr_sel(wr_sel),
		.wr_data(wr_data),
		.rd_a(rd_a),
		.rd_b(rd_b)
	);

	trace_sequencer u_trace (
		.clk(clk),
		.rst(rst),
		.rec_valid(rec_valid),
		.rec_opcode(rec_opcode),
		.rec_a(rec_a),
		.rec_b(rec_b),
		.rec_result(rec_result),
		.rec_carry(rec_carry),
		.rec_borrow(rec_borrow),
		.rec_pc(rec_pc),
		.data_out(data_out),
		.data_type(data_type),
		.data_valid(data_valid),
		.rec_next(rec_next)
	);

endmodule

//--- tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// one expected record, word k sits at index k
typedef logic [TRACE_WORDS-1:0][DATA_W-1:0] record_t;

logic [2*DATA_W-1:0] ref_rom [ROM_DEPTH];
data_t ref_regs [REG_CNT];
logic ref_carry;
logic ref_borrow;
logic [PC_W-1:0] ref_pc;
data_t ref_a;        // last alu operands and result
data_t ref_b;
data_t ref_result;

initial $readmemh(PROGRAM_FILE, ref_rom);

function automatic void model_reset();
	for (int i = 0; i < REG_CNT; i++)
		ref_regs[i] = '0;
	ref_carry = 1'b0;
	ref_borrow = 1'b0;
	ref_pc = '0;
	ref_a = '0;
	ref_b = '0;
	ref_result = '0;
endfunction

// exact signed sum folded to 8 bits, bit 7 flipped on overflow
function automatic void fold_sum(input int s, output data_t res, output logic cy,
		output logic bw);
	logic [DATA_W-1:0] w;
	w = s[DATA_W-1:0];
	cy = s > 127;
	bw = s < -128;
	res = data_t'(w);
	if (cy || bw)
		res[DATA_W-1] = ~res[DATA_W-1];
endfunction

// runs one instruction of the model, returns 0 on a halt
function automatic bit ref_step(output record_t rec);
	logic [7:0] op;
	logic [7:0] imm;
	logic [2:0] d;
	logic [2:0] s;
	logic is_alu;
	logic keep;
	logic [2:0] dst;
	data_t x;
	data_t y;
	data_t res;
	logic cy;
	logic bw;
	{op, imm} = ref_rom[ref_pc];
	d = op[5:3];
	s = op[2:0];
	rec = '0;
	if (op == 8'h76)
		return 1'b0;
	ref_pc = ref_pc + 1'b1;
	is_alu = 1'b1;
	keep = 1'b0;   // cmp leaves r0 alone
	dst = 3'd0;
	x = ref_regs[0];
	y = '0;
	res = '0;
	cy = 1'b0;
	bw = 1'b0;
	casez (op)
		8'hc3: begin
			is_alu = 1'b0;
			ref_pc = imm;
		end
		8'h3f: begin
			is_alu = 1'b0;
			ref_carry = !ref_carry;
		end
		8'b11???010: begin
			is_alu = 1'b0;
			if (ref_regs[d] > 0)
				ref_pc = imm;
		end
		8'b00???110: begin
			is_alu = 1'b0;
			ref_regs[d] = data_t'(imm);
		end
		8'b01??????: begin
			is_alu = 1'b0;
			ref_regs[d] = ref_regs[s];
		end
		8'b00???100: begin
			dst = d;
			x = ref_regs[d];
			fold_sum(int'(x) + 1, res, cy, bw);
		end
		8'b00???101: begin
			dst = d;
			x = ref_regs[d];
			fold_sum(int'(x) - 1, res, cy, bw);
		end
		8'h07: begin
			res = {x[6:0], x[7]};
			cy = ref_carry;
		end
		8'h0f: begin
			res = {x[0], x[7:1]};
			cy = ref_carry;
		end
		8'h17: begin
			res = {x[6:0], ref_carry};
			cy = x[7];
		end
		8'h1f: begin
			res = {ref_carry, x[7:1]};
			cy = x[0];
		end
		8'h2f: res = ~x;
		8'b10??????: begin
			y = ref_regs[s];
			case (d)
				3'd0: fold_sum(int'(x) + int'(y), res, cy, bw);
				3'd1: fold_sum(int'(x) + int'(y) + int'(ref_carry), res, cy, bw);
				3'd2: fold_sum(int'(x) - int'(y), res, cy, bw);
				3'd3: fold_sum(int'(x) - int'(y) - int'(ref_borrow), res, cy, bw);
				3'd4: res = x & y;
				3'd5: res = x ^ y;
				3'd6: res = x | y;
				default: begin
					fold_sum(int'(x) - int'(y), res, cy, bw);
					keep = 1'b1;
				end
			endcase
		end
		default: is_alu = 1'b0;   // nop
	endcase
	if (is_alu) begin
		ref_a = x;
		ref_b = y;
		ref_result = res;
		ref_carry = cy;
		ref_borrow = bw;
		if (!keep)
			ref_regs[dst] = res;
	end
	rec[OPCODE] = op;
	rec[OPERAND_A] = ref_a;
	rec[OPERAND_B] = ref_b;
	rec[RESULT] = ref_result;
	rec[CARRY] = {7'd0, ref_carry};
	rec[BORROW] = {7'd0, ref_borrow};
	rec[PC] = ref_pc;
	return 1'b1;
endfunction

`endif

//--- tb_cpu_top.sv
`timescale 1ns/10ps

module tb_cpu_top;
	import cpu8_pkg::*;

	localparam int HALT_TIMEOUT = 2000;   // cycles

	logic clk;
	logic rst;
	logic [DATA_W-1:0] data_out;
	trace_kind_t data_type;
	logic data_valid;
	logic halted;

	int seed;
	int word_errs = 0;
	int type_errs = 0;
	int frame_errs = 0;
	int timeouts = 0;
	int records = 0;
	int records_since_reset = 0;
	logic halt_seen = 1'b0;

	`include "tb_ref_model.svh"

	cpu_top dut (
		.clk(clk),
		.rst(rst),
		.data_out(data_out),
		.data_type(data_type),
		.data_valid(data_valid),
		.halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic check_word(input data_t got, input data_t exp, input trace_kind_t kind);
		if (got !== exp) begin
			word_errs++;
			$display("** Error at %0t: %s word got %0d (0x%02h) expected %0d (0x%02h)",
				$time, kind.name(), got, got, exp, exp);
		end
	endtask

	task automatic check_type(input trace_kind_t got, input trace_kind_t exp);
		if (got !== exp) begin
			type_errs++;
			$display("** Error at %0t: data_type got %0d expected %0d", $time, got, exp);
		end
	endtask

	// outputs sampled on the rising edge, before the dut updates them
	initial begin : compare
		record_t exp_rec;
		int idx;
		logic prev_rst;
		idx = 0;
		prev_rst = 1'b0;
		exp_rec = '0;
		forever begin
			@(posedge clk);
			if (rst) begin
				if (prev_rst && data_valid !== 1'b0) begin
					frame_errs++;
					$display("trace output seen at %0t while reset is held", $time);
				end
				model_reset();
				idx = 0;
				halt_seen = 1'b0;
				records_since_reset = 0;
			end else if (data_valid === 1'b1) begin
				if (halted === 1'b1) begin
					frame_errs++;
					$display("trace output seen at %0t after the core halted", $time);
				end
				if (idx == 0 && !ref_step(exp_rec)) begin
					frame_errs++;
					$display("trace record at %0t after the program reached HLT", $time);
				end
				check_type(data_type, trace_kind_t'(idx));
				check_word(data_out, exp_rec[idx], trace_kind_t'(idx));
				idx++;
				if (idx == TRACE_WORDS) begin
					idx = 0;
					records++;
					records_since_reset++;
				end
			end else begin
				if (idx != 0) begin
					frame_errs++;
					$display("burst at %0t ended after %0d words instead of %0d",
						$time, idx, TRACE_WORDS);
					idx = 0;
				end
				if (halted === 1'b1 && !halt_seen) begin
					halt_seen = 1'b1;
					if (ref_step(exp_rec)) begin
						frame_errs++;
						$display("core halted at %0t but the model still had an instruction",
							$time);
					end
				end
			end
			prev_rst = rst;
		end
	end

	initial begin : stimulus
		int gap;
		int cycles;
		seed = 32;
		rst = 1'b1;
		repeat (2) @(negedge clk);
		rst = 0;

		// second reset lands somewhere inside the program
		gap = 30 + ({$random(seed)} % 200);
		repeat (gap) @(negedge clk);
		if (halted === 1'b1) begin
			frame_errs++;
			$display("program halted before the second reset");
		end
		rst = 1'b1;
		repeat (2) @(negedge clk);
		rst = 1'b0;

		cycles = 0;
		while (halted !== 1'b1 && cycles < HALT_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (halted !== 1'b1) begin
			timeouts++;
			$display("timeout after %0d cycles waiting for halted", HALT_TIMEOUT);
		end

		repeat (20) @(negedge clk);   // halted core must stay quiet
		if (records_since_reset == 0) begin
			frame_errs++;
			$display("no trace records after the second reset");
		end
		if (!halt_seen) begin
			frame_errs++;
			$display("halt was never seen by the compare process");
		end

		$display("errors: word %0d, type %0d, framing %0d, timeouts %0d (%0d records)",
			word_errs, type_errs, frame_errs, timeouts, records);
		if (word_errs + type_errs + frame_errs + timeouts == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

//--- program.hex
// rom word = opcode byte then immediate byte, one word per pc starting at 0
// signed limits for add/sub, then logic, inr/dcr, rotates, jumps and a counted loop
0e7f 1601 4100 8200   // 00 mvi r1,7f  mvi r2,01  mov r0,r1  add r2
8a00 1e80 9200 4300   // 04 adc r2  mvi r3,80  sub r2  mov r0,r3
9200 9a00 b900 263c   // 08 sub r2  sbb r2  cmp r1  mvi r4,3c
ac00 2e0f a500 b400   // 0c xra r4  mvi r5,0f  ana r5  ora r4
0c00 1d00 3f00 0700   // 10 inr r1  dcr r3  cmc  rlc
0f00 1700 1f00 2f00   // 14 rrc  ral  rar  cma
3f00 1f00 c31d 0655   // 18 cmc  rar  jmp 1d  mvi r0,55 skipped
7600 0000 c22f 3603   // 1c hlt skipped  nop  jpos r0,2f not taken  mvi r6,03
3500 f220 7e00 7600   // 20 dcr r6  jpos r6,20 loop  mov r7,r6  hlt

//--- build.f
+incdir+.
cpu8_pkg.sv
alu.sv
reg_file.sv
cpu_control.sv
trace_sequencer.sv
cpu_top.sv
tb_cpu_top.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_cpu_top
FILELIST = build.f
LOG      = sim.log
FAIL_MSG = TB FAILED
PASS_MSG = TB PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run $(TOP), check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
